//--- Bender.yml
package:
  name: vdc

sources:
  - hw/vdc_pkg.sv
  - hw/vdc_beam_timing.sv
  - hw/vdc_bg_fetch.sv
  - hw/vdc_bg_serializer.sv
  - hw/vdc_video_out.sv
  - hw/vdc_top.sv
  - target: simulation
    files:
      - sim/vram_model.sv
      - sim/vdc_tb.sv

//--- files.f
hw/vdc_pkg.sv
hw/vdc_beam_timing.sv
hw/vdc_bg_fetch.sv
hw/vdc_bg_serializer.sv
hw/vdc_video_out.sv
hw/vdc_top.sv
sim/vram_model.sv
sim/vdc_tb.sv

//--- hw/vdc_beam_timing.sv
`timescale 1ns/1ps

module vdc_beam_timing #(
  parameter int unsigned hsw = 2,    // HSYNC width - 1 (chars)
  parameter int unsigned hds = 2,    // Left blank - 1
  parameter int unsigned hdw = 31,   // Display width - 1
  parameter int unsigned hde = 3,    // Right blank - 1
  parameter int unsigned vsw = 2,    // VSYNC width - 1 (lines)
  parameter int unsigned vds = 15,   // Top blank - 2
  parameter int unsigned vdw = 239,  // Display height - 1
  parameter int unsigned vde = 3     // Bottom blank
) (
  input  logic           clock,
  input  logic           reset_N,
  output vdc_pkg::beam_t beam
);

  import vdc_pkg::*;

  char_cycle_t char_cycle;
  h_state_e    h_state;
  v_state_e    v_state;
  logic [9:0]  h_cnt, v_cnt;
  logic [6:0]  tile_col;
  logic [9:0]  row;

  logic char_end;   // Last clock of a character
  logic line_end;   // Last clock of a line
  logic fetch_chr;  // Character that carries a BG fetch slot

  assign char_end  = (char_cycle == LAST_CYCLE);
  assign line_end  = char_end && (h_state == H_END) && (h_cnt == '0);
  assign fetch_chr = (h_state == H_DISP) || ((h_state == H_WAIT) && (h_cnt < 10'd2));

  //////////////////////////////////////////////////////////////////////
  // Horizontal
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock, negedge reset_N) begin
    if (!reset_N) begin
      char_cycle <= '0;
      h_state    <= H_SYNC;
      h_cnt      <= 10'(hsw);
    end else begin
      char_cycle <= char_end ? '0 : char_cycle + 1'b1;
      if (char_end) begin
        h_cnt <= h_cnt - 1'b1;           // One char gone
        if (h_cnt == '0) begin
          case (h_state)
            H_SYNC: begin h_state <= H_WAIT; h_cnt <= 10'(hds); end
            H_WAIT: begin h_state <= H_DISP; h_cnt <= 10'(hdw); end
            H_DISP: begin h_state <= H_END;  h_cnt <= 10'(hde); end
            default: begin h_state <= H_SYNC; h_cnt <= 10'(hsw); end
          endcase
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Vertical, steps once per line
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock, negedge reset_N) begin
    if (!reset_N) begin
      v_state <= V_WAIT;
      v_cnt   <= 10'(vds + 1);
    end else if (line_end) begin
      v_cnt <= v_cnt - 1'b1;
      if (v_cnt == '0) begin
        case (v_state)
          V_WAIT: begin v_state <= V_DISP; v_cnt <= 10'(vdw); end
          V_DISP: begin v_state <= V_END;  v_cnt <= 10'(vde - 1); end
          V_END:  begin v_state <= V_SYNC; v_cnt <= 10'(vsw); end
          default: begin v_state <= V_WAIT; v_cnt <= 10'(vds + 1); end
        endcase
      end
    end
  end

  // Tile column and display row
  always_ff @(posedge clock, negedge reset_N) begin
    if (!reset_N) begin
      tile_col <= '0;
      row      <= '0;
    end else begin
      if (char_end && (h_state == H_SYNC) && (h_cnt == '0))
        tile_col <= '0;                  // Fresh line, first fetch is col 0
      else if (char_end && fetch_chr)
        tile_col <= tile_col + 1'b1;

      if (v_state == V_WAIT)
        row <= '0;                       // Top of frame
      else if (char_end && (v_state == V_DISP) && (h_state == H_DISP) && (h_cnt == '0))
        row <= row + 1'b1;               // Visible part of line done
    end
  end

  always_comb begin
    beam.h_state    = h_state;
    beam.v_state    = v_state;
    beam.char_cycle = char_cycle;
    beam.h_cnt      = h_cnt;
    beam.v_cnt      = v_cnt;
    beam.tile_col   = tile_col;
    beam.row        = row;
  end

endmodule

//--- hw/vdc_bg_fetch.sv
`timescale 1ns/1ps

module vdc_bg_fetch (
  input  logic                              clock,
  input  logic                              reset_N,
  input  vdc_pkg::beam_t                    beam,
  output vdc_pkg::vram_req_t                vram_req,
  input  logic [vdc_pkg::VRAM_DW-1:0]       vram_data,
  output logic                              tile_we,
  output logic [1:0]                        tile_slot,
  output vdc_pkg::tile_line_t               tile_line
);

  import vdc_pkg::*;

  logic               fetch_on;   // This char belongs to BG fetch
  logic               sync_last;  // Last clock of HSYNC
  logic [VRAM_AW-1:0] bat_ptr;
  logic [VRAM_AW-1:0] tile_ptr;   // Row of the current tile's CG
  logic [3:0]         pal_q;
  logic [VRAM_DW-1:0] cg0_q;
  logic [1:0]         slot_q;     // Ring slot of the tile in flight
  logic               cg1_due;    // CG1 word on the bus now
  bat_entry_t         bat_word;

  assign bat_word  = bat_entry_t'(vram_data);
  assign fetch_on  = (beam.v_state == V_DISP) &&
                     ((beam.h_state == H_DISP) ||
                      ((beam.h_state == H_WAIT) && (beam.h_cnt < 10'd2)));
  assign sync_last = (beam.h_state == H_SYNC) && (beam.h_cnt == '0) &&
                     (beam.char_cycle == LAST_CYCLE);

  //////////////////////////////////////////////////////////////////////
  // VRAM address sequencing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    vram_req = '0;                       // Idle bus
    if (fetch_on) begin
      case (beam.char_cycle)
        3'd1: begin                      // BAT word
          vram_req.rd   = 1'b1;
          vram_req.addr = bat_ptr;
        end
        3'd5: begin                      // CG0, planes 0/1
          vram_req.rd   = 1'b1;
          vram_req.addr = tile_ptr;
        end
        3'd7: begin                      // CG1, planes 2/3, 8 words on
          vram_req.rd   = 1'b1;
          vram_req.addr = tile_ptr + VRAM_AW'(8);
        end
        default: ;
      endcase
    end
  end

  // BAT pointer, reloaded per line from the row's tile row
  always_ff @(posedge clock, negedge reset_N) begin
    if (!reset_N) begin
      bat_ptr <= '0;
      slot_q  <= '0;
      cg1_due <= 1'b0;
    end else begin
      if (sync_last)
        bat_ptr <= VRAM_AW'(beam.row[9:3]) << BAT_WIDTH_LOG2;
      else if (fetch_on && (beam.char_cycle == LAST_CYCLE))
        bat_ptr <= bat_ptr + 1'b1;       // Next tile of the row

      if (fetch_on && (beam.char_cycle == 3'd2))
        slot_q <= 2'(beam.tile_col % BG_PIPE_LEN);

      cg1_due <= fetch_on && (beam.char_cycle == LAST_CYCLE);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Capture, one clock after each read
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (fetch_on && (beam.char_cycle == 3'd2)) begin
      pal_q    <= bat_word.palette;
      // 16 words per tile, row inside tile picks the word
      tile_ptr <= VRAM_AW'({bat_word.tile_index, 4'b0000}) + VRAM_AW'(beam.row[2:0]);
    end
    if (fetch_on && (beam.char_cycle == 3'd6))
      cg0_q <= vram_data;
  end

  // Whole tile goes to the ring as CG1 arrives
  assign tile_we           = cg1_due;
  assign tile_slot         = slot_q;
  assign tile_line.palette = pal_q;
  assign tile_line.cg0     = cg0_q;
  assign tile_line.cg1     = vram_data;

endmodule

//--- hw/vdc_bg_serializer.sv
`timescale 1ns/1ps

module vdc_bg_serializer (
  input  logic                clock,
  input  logic                reset_N,
  input  vdc_pkg::beam_t      beam,
  input  logic                tile_we,
  input  logic [1:0]          tile_slot,
  input  vdc_pkg::tile_line_t tile_line,
  output vdc_pkg::pixel_t     pixel,
  output logic                active
);

  import vdc_pkg::*;

  tile_line_t  ring [BG_PIPE_LEN];  // Written two chars ahead of display
  logic [1:0]  rd_ptr;
  tile_line_t  cur;
  char_cycle_t x;                   // Pixel inside the tile
  logic [3:0]  color;

  assign active = (beam.h_state == H_DISP) && (beam.v_state == V_DISP);
  assign x      = beam.char_cycle;
  assign cur    = ring[rd_ptr];

  always_ff @(posedge clock) begin
    if (tile_we)
      ring[tile_slot] <= tile_line;
  end

  // Read side follows the displayed char
  always_ff @(posedge clock, negedge reset_N) begin
    if (!reset_N) begin
      rd_ptr <= '0;
    end else if (!active) begin
      rd_ptr <= '0;                     // Line starts at slot 0
    end else if (x == LAST_CYCLE) begin
      rd_ptr <= (rd_ptr == 2'(BG_PIPE_LEN - 1)) ? '0 : rd_ptr + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bit-plane extraction, MSB is leftmost pixel
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    color[0] = cur.cg0[7 - x];
    color[1] = cur.cg0[15 - x];
    color[2] = cur.cg1[7 - x];
    color[3] = cur.cg1[15 - x];

    pixel.sprite  = 1'b0;
    pixel.color   = color;
    // Colour 0 is transparent, shows as backdrop
    pixel.palette = (color == 4'd0) ? 4'd0 : cur.palette;
  end

endmodule

//--- hw/vdc_pkg.sv
package vdc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  localparam int CHAR_CLOCKS    = 8;   // Dot clocks per character
  localparam int VRAM_AW        = 16;  // VRAM word address
  localparam int VRAM_DW        = 16;  // VRAM data word
  localparam int BG_PIPE_LEN    = 3;   // Tile ring slots, fetch runs 2 ahead
  localparam int BAT_WIDTH_LOG2 = 5;   // 32 tiles per BAT row

  // Position inside one character
  typedef logic [$clog2(CHAR_CLOCKS)-1:0] char_cycle_t;

  localparam char_cycle_t LAST_CYCLE = char_cycle_t'(CHAR_CLOCKS - 1);

  //////////////////////////////////////////////////////////////////////
  // Beam phases
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    H_SYNC,  // Sync pulse
    H_WAIT,  // Left blank, last two chars prefetch
    H_DISP,  // Visible part
    H_END    // Right blank
  } h_state_e;

  typedef enum logic [1:0] {
    V_WAIT,  // Top blank
    V_DISP,  // Visible lines
    V_END,   // Bottom blank
    V_SYNC   // Sync pulse
  } v_state_e;

  // Beam position seen by every stage
  typedef struct packed {
    h_state_e    h_state;
    v_state_e    v_state;
    char_cycle_t char_cycle;
    logic [9:0]  h_cnt;     // Down-counter, chars left in phase
    logic [9:0]  v_cnt;     // Down-counter, lines left in phase
    logic [6:0]  tile_col;  // Tile under fetch in this line
    logic [9:0]  row;       // Display line index
  } beam_t;

  //////////////////////////////////////////////////////////////////////
  // Data words
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [3:0]  palette;
    logic [11:0] tile_index;
  } bat_entry_t;

  // One tile row, both bit-plane pairs
  typedef struct packed {
    logic [3:0]         palette;
    logic [VRAM_DW-1:0] cg0;  // Planes 0 and 1
    logic [VRAM_DW-1:0] cg1;  // Planes 2 and 3
  } tile_line_t;

  typedef struct packed {
    logic               rd;
    logic [VRAM_AW-1:0] addr;
  } vram_req_t;

  // VD pixel code
  typedef struct packed {
    logic       sprite;   // Always 0, no sprite path
    logic [3:0] palette;
    logic [3:0] color;
  } pixel_t;

endpackage

//--- hw/vdc_top.sv
`timescale 1ns/1ps

module vdc_top #(
  parameter int unsigned hsw = 2,
  parameter int unsigned hds = 2,
  parameter int unsigned hdw = 31,
  parameter int unsigned hde = 3,
  parameter int unsigned vsw = 2,
  parameter int unsigned vds = 15,
  parameter int unsigned vdw = 239,
  parameter int unsigned vde = 3
) (
  input  logic                        clock,
  input  logic                        reset_N,
  output vdc_pkg::vram_req_t          vram_req,
  input  logic [vdc_pkg::VRAM_DW-1:0] vram_data,
  output logic                        hsync_n,
  output logic                        vsync_n,
  output logic                        display,
  output vdc_pkg::pixel_t             vd
);

  import vdc_pkg::*;

  beam_t      beam;
  logic       tile_we;
  logic [1:0] tile_slot;
  tile_line_t tile_line;
  pixel_t     pixel;
  logic       active;

  //////////////////////////////////////////////////////////////////////
  // Beam timing, fetch, serializer, output stage
  //////////////////////////////////////////////////////////////////////

  vdc_beam_timing #(
    .hsw(hsw), .hds(hds), .hdw(hdw), .hde(hde),
    .vsw(vsw), .vds(vds), .vdw(vdw), .vde(vde)
  ) beam_i (
    .clock  (clock),
    .reset_N(reset_N),
    .beam   (beam)
  );

  vdc_bg_fetch fetch_i (
    .clock    (clock),
    .reset_N  (reset_N),
    .beam     (beam),
    .vram_req (vram_req),
    .vram_data(vram_data),
    .tile_we  (tile_we),
    .tile_slot(tile_slot),
    .tile_line(tile_line)
  );

  vdc_bg_serializer ser_i (
    .clock    (clock),
    .reset_N  (reset_N),
    .beam     (beam),
    .tile_we  (tile_we),
    .tile_slot(tile_slot),
    .tile_line(tile_line),
    .pixel    (pixel),
    .active   (active)
  );

  vdc_video_out out_i (
    .clock  (clock),
    .reset_N(reset_N),
    .beam   (beam),
    .pixel  (pixel),
    .active (active),
    .hsync_n(hsync_n),
    .vsync_n(vsync_n),
    .display(display),
    .vd     (vd)
  );

endmodule

//--- hw/vdc_video_out.sv
`timescale 1ns/1ps

module vdc_video_out (
  input  logic            clock,
  input  logic            reset_N,
  input  vdc_pkg::beam_t  beam,
  input  vdc_pkg::pixel_t pixel,
  input  logic            active,
  output logic            hsync_n,
  output logic            vsync_n,
  output logic            display,
  output vdc_pkg::pixel_t vd
);

  import vdc_pkg::*;

  logic   hs_next, vs_next;
  pixel_t vd_next;

  // Sync pulses are active low
  assign hs_next = (beam.h_state != H_SYNC);
  assign vs_next = (beam.v_state != V_SYNC);
  assign vd_next = active ? pixel : '0;     // Black outside the window

  //////////////////////////////////////////////////////////////////////
  // Output register, one clock behind the beam
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock, negedge reset_N) begin
    if (!reset_N) begin
      hsync_n <= 1'b0;     // Beam starts in HSYNC
      vsync_n <= 1'b1;
      display <= 1'b0;
      vd      <= '0;
    end else begin
      hsync_n <= hs_next;
      vsync_n <= vs_next;
      display <= active;
      vd      <= vd_next;
    end
  end

endmodule

//--- sim/vdc_tb.sv
`timescale 1ns/1ps

module vdc_tb;

  import vdc_pkg::*;

  // Small raster of 10 chars by 17 lines
  localparam int HSW = 1;
  localparam int HDS = 1;
  localparam int HDW = 3;
  localparam int HDE = 1;
  localparam int VSW = 1;
  localparam int VDS = 1;
  localparam int VDW = 9;
  localparam int VDE = 2;

  localparam int LINE_CLKS  = (HSW + HDS + HDW + HDE + 4) * CHAR_CLOCKS;
  localparam int FRAME_CLKS = ((VDS + 2) + (VDW + 1) + VDE + (VSW + 1)) * LINE_CLKS;
  localparam int PIX_W      = (HDW + 1) * CHAR_CLOCKS;  // Pixels per line
  localparam int LIMIT      = 3 * FRAME_CLKS + 100;     // Clocks after reset

  logic               clock;
  logic               reset_N;
  vram_req_t          vram_req;
  logic [VRAM_DW-1:0] vram_data;
  logic               hsync_n;
  logic               vsync_n;
  logic               display;
  pixel_t             vd;

  int     errors;
  int     checks;
  int     cycles;
  integer seed;
  int     dump_line;            // Line listed in full if it has errors
  int     hs_fall;              // Clock of last hsync fall or -1
  int     vs_fall;
  int     vs_falls;
  int     y;                    // Display line inside the frame
  int     k;                    // Pixel inside the line
  int     line_errors;          // Error count as the line began
  logic   hs_prev, vs_prev, ds_prev;
  pixel_t line_vd [PIX_W];

  always #5 clock = ~clock;

  vdc_top #(
    .hsw(HSW), .hds(HDS), .hdw(HDW), .hde(HDE),
    .vsw(VSW), .vds(VDS), .vdw(VDW), .vde(VDE)
  ) dut_i (
    .clock    (clock),
    .reset_N  (reset_N),
    .vram_req (vram_req),
    .vram_data(vram_data),
    .hsync_n  (hsync_n),
    .vsync_n  (vsync_n),
    .display  (display),
    .vd       (vd)
  );

  vram_model vram_i (
    .clock  (clock),
    .reset_N(reset_N),
    .req    (vram_req),
    .data   (vram_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] vram_word(input logic [15:0] a);
    return {a[7:0], a[15:8]} ^ (a * 16'h2f6d) ^ 16'ha55a;
  endfunction

  // Expected VD for display line ln and pixel p
  function automatic logic [8:0] ref_pixel(input int ln, input int p);
    logic [15:0] bat, base, cg0, cg1;
    int          x;
    logic [3:0]  c;
    bat  = vram_word(16'(((ln / 8) << BAT_WIDTH_LOG2) + p / CHAR_CLOCKS));
    base = {bat[11:0], 4'b0000} + 16'(ln % 8);   // 16 words per tile
    cg0  = vram_word(base);
    cg1  = vram_word(base + 16'd8);
    x    = p % CHAR_CLOCKS;
    c    = {cg1[15 - x], cg1[7 - x], cg0[15 - x], cg0[7 - x]};
    return (c == 4'd0) ? 9'd0 : {1'b0, bat[15:12], c};  // Index 0 is backdrop
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("mismatch %s: got %0h, expected %0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    clock       = 1'b0;
    reset_N     = 1'b0;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    hs_fall     = -1;
    vs_fall     = -1;
    vs_falls    = 0;
    y           = 0;
    k           = 0;
    line_errors = 0;
    hs_prev     = 1'b0;          // Beam starts in HSYNC
    vs_prev     = 1'b1;
    ds_prev     = 1'b0;
    seed        = 32'hf243;
    dump_line   = $unsigned($random(seed)) % (VDW + 1);
    repeat (16) @(posedge clock);
    expect_equal("hsync_n in reset", hsync_n, 0);
    expect_equal("vsync_n in reset", vsync_n, 1);
    expect_equal("display in reset", display, 0);
    expect_equal("vram_req.rd in reset", vram_req.rd, 0);
    expect_equal("vd in reset", vd, 0);
    #1 reset_N = 1'b1;
    wait (vs_falls == 3);        // Two whole frames measured
    @(negedge clock);
    finish_run();
  end

  initial begin
    wait (cycles >= LIMIT);
    $display("timeout: the DUT did not finish three frames within %0d clocks", LIMIT);
    errors = errors + 1;
    finish_run();
  end

  //////////////////////////////////////////////////////////////////////
  // Comparing process sampling mid-cycle
  //////////////////////////////////////////////////////////////////////

  always @(negedge clock) begin
    if (reset_N) begin
      cycles = cycles + 1;
      if (hs_prev && !hsync_n) begin      // Line boundary
        if (hs_fall >= 0)
          expect_equal("line period", cycles - hs_fall, LINE_CLKS);
        hs_fall = cycles;
      end
      if (!hs_prev && hsync_n && hs_fall >= 0)
        expect_equal("hsync_n low clocks", cycles - hs_fall, (HSW + 1) * CHAR_CLOCKS);
      if (vs_prev && !vsync_n) begin      // Frame boundary
        if (vs_fall >= 0)
          expect_equal("frame period", cycles - vs_fall, FRAME_CLKS);
        expect_equal("display lines", y, VDW + 1);
        vs_fall   = cycles;
        vs_falls  = vs_falls + 1;
        y         = 0;
        dump_line = $unsigned($random(seed)) % (VDW + 1);
      end
      if (!vs_prev && vsync_n && vs_fall >= 0)
        expect_equal("vsync_n low clocks", cycles - vs_fall, (VSW + 1) * LINE_CLKS);
      if (display) begin
        if (k == 0)
          line_errors = errors;
        if (k < PIX_W)
          line_vd[k] = vd;
        expect_equal("vd", vd, ref_pixel(y, k));
        k = k + 1;
      end else begin
        expect_equal("vd", vd, 0);        // Blank outside the window
        if (ds_prev) begin
          expect_equal("display high clocks", k, PIX_W);
          if (y == dump_line && errors != line_errors)
            for (int i = 0; i < PIX_W; i++)
              $display("line %0d pixel %0d: vd %h, expected %h",
                       y, i, line_vd[i], ref_pixel(y, i));
          y = y + 1;
          k = 0;
        end
      end
      hs_prev = hsync_n;
      vs_prev = vsync_n;
      ds_prev = display;
    end
  end

endmodule

//--- sim/vram_model.sv
`timescale 1ns/1ps

module vram_model (
  input  logic                        clock,
  input  logic                        reset_N,
  input  vdc_pkg::vram_req_t          req,
  output logic [vdc_pkg::VRAM_DW-1:0] data
);

  import vdc_pkg::*;

  // Each address gets its own word, all 16 address bits mixed in
  function automatic logic [VRAM_DW-1:0] word_at(input logic [VRAM_AW-1:0] a);
    return {a[7:0], a[15:8]} ^ (a * 16'h2f6d) ^ 16'ha55a;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Read port, one clock latency
  //////////////////////////////////////////////////////////////////////

  always @(posedge clock, negedge reset_N) begin
    if (!reset_N)
      data <= '0;
    else if (req.rd)
      data <= #1 word_at(req.addr);  // Moves just after the edge
  end

endmodule
